//--- logic/mmm_pkg.sv
//////////////////////////////
// mmm package
// widths, limb types and enums shared by the montgomery multiplier
//////////////////////////////
package mmm_pkg;

    // operand and limb geometry
    localparam int OP_W   = 256;
    localparam int LIMB_W = 87;
    localparam int N_LIMB = 3;
    // montgomery radix is 2^R_W, three full limbs
    localparam int R_W    = N_LIMB * LIMB_W;
    // wide enough for a six limb product
    localparam int ACC_W  = 2 * N_LIMB * LIMB_W;
    // limb pairs walked in one stage
    localparam int N_STEP = N_LIMB * N_LIMB;

    typedef logic [OP_W-1:0]   op_word_t;
    typedef logic [R_W-1:0]    r_word_t;
    typedef logic [OP_W:0]     res_t;
    typedef logic [LIMB_W-1:0] limb_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [1:0]        limb_idx_t;
    typedef logic [3:0]        step_t;

    // what the MAC multiplies during a stage
    typedef enum logic [1:0] {
        OP_AB,
        OP_QM,
        OP_UM
    } mac_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AB,
        ST_QM,
        ST_UM,
        ST_DONE
    } mmm_state_e;

endpackage

//--- logic/mmm_step_if.sv
//////////////////////////////
// per-step control from the FSM and step counter to the datapath
//////////////////////////////
interface mmm_step_if;
    import mmm_pkg::*;

    mac_op_e   op;
    logic      start;
    logic      step_en;
    logic      load;
    limb_idx_t i_idx;
    limb_idx_t j_idx;
    logic      last;

    modport ctrl (
        output op,
        output start,
        output step_en,
        output load,
        input  last
    );

    modport cnt (
        input  start,
        input  step_en,
        output i_idx,
        output j_idx,
        output last
    );

    modport dp (
        input  op,
        input  start,
        input  step_en,
        input  load,
        input  i_idx,
        input  j_idx
    );

endinterface

//--- logic/mmm_ctrl.sv
//////////////////////////////
// mmm controller
// runs both handshakes and steps through the ab, qm and um stages
//////////////////////////////
module mmm_ctrl (
    input  logic        i_clk,
    input  logic        i_rstn,
    input  logic        i_valid,
    output logic        o_ready,
    output logic        o_valid,
    input  logic        i_ready,
    mmm_step_if.ctrl    step
);
    import mmm_pkg::*;

    mmm_state_e state_q;
    mmm_state_e state_d;
    logic       start_q;
    logic       accept;
    logic       in_stage_d;

    // only one operation in flight, so input is taken in idle only
    assign accept = i_valid && (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_valid) begin
                    state_d = ST_AB;
                end
            end
            ST_AB: begin
                if (step.last) begin
                    state_d = ST_QM;
                end
            end
            ST_QM: begin
                if (step.last) begin
                    state_d = ST_UM;
                end
            end
            ST_UM: begin
                if (step.last) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                // hold the result until the consumer takes it
                if (i_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign in_stage_d = (state_d == ST_AB) || (state_d == ST_QM) || (state_d == ST_UM);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // first cycle of every stage
            start_q <= in_stage_d && (state_d != state_q);
        end
    end

    ////////////////////////////////
    // step control
    ////////////////////////////////
    always_comb begin
        case (state_q)
            ST_QM:   step.op = OP_QM;
            ST_UM:   step.op = OP_UM;
            default: step.op = OP_AB;
        endcase
    end

    assign step.start   = start_q;
    assign step.step_en = (state_q == ST_AB) || (state_q == ST_QM) || (state_q == ST_UM);
    assign step.load    = accept;

    assign o_ready = (state_q == ST_IDLE);
    assign o_valid = (state_q == ST_DONE);

endmodule

//--- logic/limb_step_counter.sv
//////////////////////////////
// limb step counter
// walks the nine limb pairs of a stage
//////////////////////////////
module limb_step_counter (
    input  logic        i_clk,
    input  logic        i_rstn,
    mmm_step_if.cnt     step
);
    import mmm_pkg::*;

    step_t cnt_q;
    step_t cnt_cur;

    // start forces step zero in the same cycle
    assign cnt_cur = step.start ? step_t'(0) : cnt_q;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            cnt_q <= '0;
        end else if (step.step_en) begin
            cnt_q <= step_t'(cnt_cur + 1'b1);
        end
    end

    // row-major walk, i selects the left limb and j the right limb
    assign step.i_idx = limb_idx_t'(cnt_cur / N_LIMB);
    assign step.j_idx = limb_idx_t'(cnt_cur % N_LIMB);
    assign step.last  = step.step_en && (cnt_cur == step_t'(N_STEP - 1));

endmodule

//--- logic/operand_bank.sv
//////////////////////////////
// operand bank
// holds a, b, m, m', T and u and picks the limb pair for each step
//////////////////////////////
module operand_bank (
    input  logic             i_clk,
    input  logic             i_rstn,
    input  mmm_pkg::op_word_t i_a,
    input  mmm_pkg::op_word_t i_b,
    input  mmm_pkg::op_word_t i_m,
    input  mmm_pkg::r_word_t  i_m_inv,
    input  mmm_pkg::acc_t     i_acc,
    mmm_step_if.dp            step,
    output mmm_pkg::limb_t    o_x,
    output mmm_pkg::limb_t    o_y,
    output mmm_pkg::acc_t     o_t
);
    import mmm_pkg::*;

    r_word_t a_q;
    r_word_t b_q;
    r_word_t m_q;
    r_word_t m_inv_q;
    r_word_t u_q;
    acc_t    t_q;
    mac_op_e op_q;
    logic    stage_chg;
    r_word_t left;
    r_word_t right;

    // new stage when start comes with an op not seen before
    assign stage_chg = step.step_en && step.start && (step.op != op_q);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            op_q <= OP_AB;
        end else if (step.step_en && step.start) begin
            op_q <= step.op;
        end
    end

    ////////////////////////////////
    // operand and stage storage
    ////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (step.load) begin
            // zero-extend to three limbs
            a_q     <= {{(R_W - OP_W){1'b0}}, i_a};
            b_q     <= {{(R_W - OP_W){1'b0}}, i_b};
            m_q     <= {{(R_W - OP_W){1'b0}}, i_m};
            m_inv_q <= i_m_inv;
        end
        // accumulator still holds the previous stage result on the first step
        if (stage_chg && (step.op == OP_QM)) begin
            t_q <= i_acc;
        end
        if (stage_chg && (step.op == OP_UM)) begin
            u_q <= i_acc[R_W-1:0];
        end
    end

    ////////////////////////////////
    // limb pair select
    ////////////////////////////////
    always_comb begin
        case (step.op)
            OP_AB: begin
                left  = a_q;
                right = b_q;
            end
            OP_QM: begin
                // T mod R, taken straight from the accumulator until it is stored
                left  = stage_chg ? i_acc[R_W-1:0] : t_q[R_W-1:0];
                right = m_inv_q;
            end
            default: begin
                left  = stage_chg ? i_acc[R_W-1:0] : u_q;
                right = m_q;
            end
        endcase
    end

    assign o_x = left[step.i_idx * LIMB_W +: LIMB_W];
    assign o_y = right[step.j_idx * LIMB_W +: LIMB_W];
    assign o_t = t_q;

endmodule

//--- logic/limb_mac.sv
//////////////////////////////
// limb MAC
// 87x87 product added into the accumulator at limb offset i+j
//////////////////////////////
module limb_mac (
    input  logic           i_clk,
    input  logic           i_rstn,
    input  mmm_pkg::limb_t i_x,
    input  mmm_pkg::limb_t i_y,
    input  mmm_pkg::acc_t  i_t,
    mmm_step_if.dp         step,
    output mmm_pkg::acc_t  o_acc,
    output mmm_pkg::res_t  o_res
);
    import mmm_pkg::*;

    logic [2*LIMB_W-1:0] prod;
    logic [2:0]          pos;
    acc_t                prod_sh;
    acc_t                acc_base;
    acc_t                acc_q;

    assign prod = i_x * i_y;
    assign pos  = {1'b0, step.i_idx} + {1'b0, step.j_idx};

    // product lands at limb position i+j
    assign prod_sh = acc_t'(prod) << (pos * LIMB_W);

    // first step of a stage starts from zero, or from T for the reduction
    always_comb begin
        if (step.start) begin
            acc_base = (step.op == OP_UM) ? i_t : '0;
        end else begin
            acc_base = acc_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            acc_q <= '0;
        end else if (step.step_en) begin
            acc_q <= acc_base + prod_sh;
        end
    end

    assign o_acc = acc_q;
    // (T + u*m) / R, below 2m so 257 bits are enough
    assign o_res = acc_q[R_W +: OP_W + 1];

endmodule

//--- logic/mmm_top.sv
//////////////////////////////
// 256-bit montgomery multiplier top
//////////////////////////////
module mmm_top (
    input  logic              i_clk,
    input  logic              i_rstn,
    input  logic              i_valid,
    output logic              o_ready,
    input  mmm_pkg::op_word_t i_a,
    input  mmm_pkg::op_word_t i_b,
    input  mmm_pkg::op_word_t i_m,
    input  mmm_pkg::r_word_t  i_m_inv,
    output logic              o_valid,
    input  logic              i_ready,
    output mmm_pkg::res_t     o_res
);
    import mmm_pkg::*;

    limb_t x;
    limb_t y;
    acc_t  acc;
    acc_t  t_word;

    mmm_step_if u_step_if ();

    mmm_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .step    (u_step_if.ctrl)
    );

    limb_step_counter u_counter (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .step   (u_step_if.cnt)
    );

    operand_bank u_bank (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_m     (i_m),
        .i_m_inv (i_m_inv),
        .i_acc   (acc),
        .step    (u_step_if.dp),
        .o_x     (x),
        .o_y     (y),
        .o_t     (t_word)
    );

    limb_mac u_mac (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .i_x    (x),
        .i_y    (y),
        .i_t    (t_word),
        .step   (u_step_if.dp),
        .o_acc  (acc),
        .o_res  (o_res)
    );

endmodule

//--- test/mmm_props.sv
//////////////////////////////
// handshake properties of the montgomery multiplier
//////////////////////////////
module mmm_props (
    input logic          i_clk,
    input logic          i_rstn,
    input logic          o_ready,
    input logic          o_valid,
    input logic          i_ready,
    input mmm_pkg::res_t o_res
);
    int n_fail;

    initial n_fail = 0;

    // result is held until the consumer takes it
    hold_result: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        o_valid && !i_ready |=> o_valid && $stable(o_res)
    ) else begin
        $error("o_valid or o_res changed before the output transfer");
        n_fail = n_fail + 1;
    end

    // input side closed while a result is pending
    ready_valid_excl: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        !(o_ready && o_valid)
    ) else begin
        $error("o_ready and o_valid high together");
        n_fail = n_fail + 1;
    end

    valid_low_after_reset: assert property (
        @(posedge i_clk) $rose(i_rstn) |-> !o_valid
    ) else begin
        $error("o_valid high right after reset release");
        n_fail = n_fail + 1;
    end

endmodule

//--- test/tb_mmm.sv
//////////////////////////////
// montgomery multiplier testbench
// directed tests checked against a wide arithmetic model
//////////////////////////////
module tb_mmm;
    import mmm_pkg::*;

    localparam int CLK_PER      = 40;
    localparam int N_RAND       = 50;
    localparam int N_B2B        = 6;
    localparam int N_OPS        = 4 + N_RAND + 2 + N_B2B + 2;
    localparam int OP_TIMEOUT   = 40;
    // the extra two slots cover reset and the back-pressure hold
    localparam int WATCHDOG_CYC = (N_OPS + 2) * 40;

    logic        i_clk = 1'b0;
    logic        i_rstn;
    logic        i_valid;
    logic        o_ready;
    op_word_t    i_a;
    op_word_t    i_b;
    op_word_t    i_m;
    r_word_t     i_m_inv;
    logic        o_valid;
    logic        i_ready;
    res_t        o_res;
    logic [31:0] rng_state;

    always #(CLK_PER / 2) i_clk = ~i_clk;

    mmm_top dut (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_m     (i_m),
        .i_m_inv (i_m_inv),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_res   (o_res)
    );

    bind mmm_top mmm_props u_props (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_res   (o_res)
    );

    ////////////////////////////////
    // random values and reference model
    ////////////////////////////////
    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic op_word_t rand_word();
        op_word_t w;
        for (int k = 0; k < OP_W / 32; k++) begin
            w[k*32 +: 32] = xorshift32();
        end
        return w;
    endfunction

    // odd modulus of varying length
    function automatic op_word_t rand_modulus();
        op_word_t m;
        m = rand_word() >> (xorshift32() % 64);
        m[0] = 1'b1;
        m[OP_W-65] = 1'b1;
        return m;
    endfunction

    function automatic op_word_t rand_below(op_word_t m);
        return rand_word() % m;
    endfunction

    // -m^-1 mod R, each newton step doubles the correct low bits
    function automatic r_word_t neg_inv(op_word_t m);
        r_word_t x;
        r_word_t mm;
        mm = m;
        x  = 1;
        for (int k = 0; k < 9; k++) begin
            x = x * (r_word_t'(2) - mm * x);
        end
        return -x;
    endfunction

    function automatic res_t model_res(op_word_t a, op_word_t b, op_word_t m);
        logic [2*OP_W-1:0] t;
        r_word_t           u;
        logic [ACC_W:0]    sum;
        t   = a * b;
        u   = t[R_W-1:0] * neg_inv(m);
        sum = t + u * m;
        return res_t'(sum >> R_W);
    endfunction

    ////////////////////////////////
    // checks
    ////////////////////////////////
    task automatic fail_now(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_res(string name, res_t got, res_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_op(op_word_t a, op_word_t b, op_word_t m, res_t got);
        logic [2*OP_W-1:0] ab;
        logic [R_W+OP_W:0] res_r;
        ab    = a * b;
        res_r = {got, {R_W{1'b0}}};
        check_res("o_res", got, model_res(a, b, m));
        check_flag("o_res_below_2m", got < {m, 1'b0}, 1'b1);
        // o_res * R must match a * b in the residue ring
        check_res("o_res_times_r_mod_m", res_t'(res_r % m), res_t'(ab % m));
    endtask

    ////////////////////////////////
    // handshake helpers, entered on a falling edge
    ////////////////////////////////
    task automatic send_op(op_word_t a, op_word_t b, op_word_t m);
        int n;
        n = 0;
        while (!o_ready) begin
            @(negedge i_clk);
            n++;
            if (n > OP_TIMEOUT) begin
                fail_now("o_ready did not come back, no new operation could be sent");
            end
        end
        i_valid = 1'b1;
        i_a     = a;
        i_b     = b;
        i_m     = m;
        i_m_inv = neg_inv(m);
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    task automatic wait_result(output res_t r);
        int n;
        n = 0;
        while (!o_valid) begin
            @(negedge i_clk);
            n++;
            if (n > OP_TIMEOUT) begin
                fail_now("o_valid never rose after an accepted operation");
            end
        end
        r = o_res;
    endtask

    task automatic release_result();
        i_ready = 1'b1;
        @(negedge i_clk);
        i_ready = 1'b0;
    endtask

    task automatic run_op(op_word_t a, op_word_t b, op_word_t m);
        res_t r;
        send_op(a, b, m);
        wait_result(r);
        release_result();
        check_op(a, b, m, r);
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////
    task automatic test_corners();
        op_word_t m;
        m = rand_modulus();
        run_op('0, rand_below(m), m);
        run_op(op_word_t'(1), rand_below(m), m);
        run_op(rand_below(m), op_word_t'(1), m);
        run_op(m - 1, m - 1, m);
    endtask

    task automatic test_random();
        op_word_t m;
        for (int k = 0; k < N_RAND; k++) begin
            m = rand_modulus();
            run_op(rand_below(m), rand_below(m), m);
        end
    endtask

    task automatic test_backpressure();
        op_word_t m;
        op_word_t a;
        op_word_t b;
        res_t     r0;
        int       hold;
        m = rand_modulus();
        a = rand_below(m);
        b = rand_below(m);
        send_op(a, b, m);
        wait_result(r0);
        hold = 2 + int'(xorshift32() % 12);
        for (int k = 0; k < hold; k++) begin
            // other operands offered while the result waits
            i_valid = (k % 2 == 0);
            i_a     = rand_word();
            i_b     = rand_word();
            @(negedge i_clk);
            check_flag("o_valid", o_valid, 1'b1);
            check_flag("o_ready", o_ready, 1'b0);
            check_res("o_res", o_res, r0);
        end
        i_valid = 1'b0;
        release_result();
        check_flag("o_valid", o_valid, 1'b0);
        check_op(a, b, m, r0);
        m = rand_modulus();
        run_op(rand_below(m), rand_below(m), m);
    endtask

    task automatic test_back_to_back();
        op_word_t m;
        op_word_t a;
        op_word_t b;
        res_t     r;
        m       = rand_modulus();
        i_ready = 1'b1;
        for (int k = 0; k < N_B2B; k++) begin
            a = rand_below(m);
            b = rand_below(m);
            send_op(a, b, m);
            wait_result(r);
            @(negedge i_clk);
            check_flag("o_valid", o_valid, 1'b0);
            check_flag("o_ready", o_ready, 1'b1);
            check_op(a, b, m, r);
        end
        i_ready = 1'b0;
    endtask

    task automatic test_reset_mid_op();
        op_word_t m;
        m = rand_modulus();
        send_op(rand_below(m), rand_below(m), m);
        repeat (2 + int'(xorshift32() % 20)) @(negedge i_clk);
        i_rstn = 1'b0;
        @(negedge i_clk);
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_ready", o_ready, 1'b1);
        @(negedge i_clk);
        i_rstn = 1'b1;
        @(negedge i_clk);
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_ready", o_ready, 1'b1);
        run_op(rand_below(m), rand_below(m), m);
    endtask

    ////////////////////////////////
    // run control
    ////////////////////////////////
    always @(negedge i_clk) begin
        if (dut.u_props.n_fail != 0) begin
            fail_now("a bound handshake assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PER);
        fail_now("watchdog expired, the tests did not finish in time");
    end

    initial begin
        i_rstn    = 1'b0;
        i_valid   = 1'b0;
        i_ready   = 1'b0;
        i_a       = '0;
        i_b       = '0;
        i_m       = '0;
        i_m_inv   = '0;
        rng_state = 32'h9bec;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;
        @(negedge i_clk);
        test_corners();
        test_random();
        test_backpressure();
        test_back_to_back();
        test_reset_mid_op();
        if (dut.u_props.n_fail == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/mmm_pkg.sv
logic/mmm_step_if.sv
logic/mmm_ctrl.sv
logic/limb_step_counter.sv
logic/operand_bank.sv
logic/limb_mac.sv
logic/mmm_top.sv
test/mmm_props.sv
test/tb_mmm.sv

//--- Bender.yml
package:
  name: mmm

sources:
  - files:
      - logic/mmm_pkg.sv
      - logic/mmm_step_if.sv
      - logic/mmm_ctrl.sv
      - logic/limb_step_counter.sv
      - logic/operand_bank.sv
      - logic/limb_mac.sv
      - logic/mmm_top.sv
  - target: test
    files:
      - test/mmm_props.sv
      - test/tb_mmm.sv
